// File: Makefile
# Verilator build and run for the load/store unit testbench

TOP := lsu_tb

.PHONY: all compile run clean

all: run

compile: obj_dir/$(TOP)

obj_dir/$(TOP): sim.f hw/*.sv dv/*.sv
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f sim.f -o $(TOP)

# pass only when the pass line shows up in the output
run: compile
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf obj_dir

// File: dv/lsu_tb.sv
`timescale 1ns/1ps

module lsu_tb;

  import lsu_pkg::*;

  localparam int MEM_WORDS = 256;
  localparam int MEM_BYTES = MEM_WORDS * 4;
  localparam int PERIOD_NS = 100;

  // requests per phase
  localparam int N_FILL = MEM_WORDS;
  localparam int N_WORD = 64;
  localparam int N_LANE = 24;
  localparam int N_MIS  = 15;
  localparam int N_MIX  = 300;
  localparam int N_WRAP = 32;
  localparam int N_REQ  = N_FILL + N_WORD + N_LANE + N_MIS + N_MIX + N_WRAP;

  typedef struct packed {
    word_t res;
    logic  mis;
  } ref_res_t;

  // expected result plus the cycle its pulse is due in
  typedef struct packed {
    ref_res_t    r;
    int unsigned due;
  } exp_t;

  logic     clk;
  logic     arst_n;
  logic     pre_valid;
  lsu_req_t req;
  word_t    lsu_res;
  logic     misaligned;
  logic     post_valid;

  // byte-wide model of the data memory
  logic [7:0]  ref_mem [MEM_BYTES];
  exp_t        exp_q [$];
  int unsigned cycle = 0;

  tb_clock #(
    .PERIOD_NS    (PERIOD_NS),
    .RESET_CYCLES (4)
  ) u_clock (
    .o_clk    (clk),
    .o_arst_n (arst_n)
  );

  lsu_top #(
    .MEM_WORDS (MEM_WORDS)
  ) lsu_top_inst (
    .i_clk        (clk),
    .i_arst_n     (arst_n),
    .i_pre_valid  (pre_valid),
    .i_req        (req),
    .o_lsu_res    (lsu_res),
    .o_misaligned (misaligned),
    .o_post_valid (post_valid)
  );

  // rising edges since time zero
  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_word(input word_t got, input word_t exp, input string what);
    if (got !== exp) begin
      report_failure($sformatf("mismatch at %0t: %s is %08h, expected %08h",
                               $time, what, got, exp));
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      report_failure($sformatf("mismatch at %0t: %s is %b, expected %b",
                               $time, what, got, exp));
    end
  endtask

  // bytes touched by the op or zero for none
  function automatic int unsigned access_bytes(input lsu_op_e op);
    case (op)
      LSU_LB, LSU_LBU, LSU_SB: return 1;
      LSU_LH, LSU_LHU, LSU_SH: return 2;
      LSU_LW, LSU_SW:          return 4;
      default:                 return 0;
    endcase
  endfunction

  function automatic logic is_store(input lsu_op_e op);
    return op inside {LSU_SB, LSU_SH, LSU_SW};
  endfunction

  // applies one request to the model memory at issue time
  function automatic ref_res_t lsu_ref(input lsu_req_t r);
    ref_res_t    res;
    int unsigned size;
    int unsigned base;
    word_t       val;
    res  = '0;
    size = access_bytes(r.op);
    if (size == 0) begin
      return res;
    end
    res.mis = (r.addr % size) != 0;
    // upper address bits fall away
    base = r.addr % MEM_BYTES;
    if (res.mis) begin
      return res;
    end
    if (is_store(r.op)) begin
      for (int k = 0; k < size; k++) begin
        ref_mem[base + k] = r.wdata[8*k +: 8];
      end
      return res;
    end
    // little endian with unused upper bytes left zero
    val = '0;
    for (int k = 0; k < size; k++) begin
      val[8*k +: 8] = ref_mem[base + k];
    end
    case (r.op)
      LSU_LB:  res.res = {{24{val[7]}}, val[7:0]};
      LSU_LH:  res.res = {{16{val[15]}}, val[15:0]};
      default: res.res = val;
    endcase
    return res;
  endfunction

  // scrambled value per word index
  function automatic word_t fill_word(input int unsigned idx);
    return (idx * 32'h9e3779b1) ^ {idx[15:0], ~idx[15:0]};
  endfunction

  function automatic lsu_op_e random_load_op();
    case ($urandom_range(4))
      0:       return LSU_LB;
      1:       return LSU_LH;
      2:       return LSU_LW;
      3:       return LSU_LBU;
      default: return LSU_LHU;
    endcase
  endfunction

  function automatic lsu_op_e random_op();
    case ($urandom_range(2))
      0:       return LSU_SB;
      1:       return LSU_SH;
      default: return ($urandom_range(1) == 0) ? LSU_SW : random_load_op();
    endcase
  endfunction

  // mostly aligned addresses over the full 32-bit range
  function automatic addr_t random_addr(input lsu_op_e op);
    addr_t a;
    a = $urandom();
    if ($urandom_range(3) != 0) begin
      a = a - (a % access_bytes(op));
    end
    return a;
  endfunction

  // drive one request on the falling edge and queue its expectation
  task automatic issue(input lsu_op_e op, input addr_t addr, input word_t wdata);
    exp_t e;
    @(negedge clk);
    pre_valid = 1'b1;
    req.op    = op;
    req.addr  = addr;
    req.wdata = wdata;
    e.r       = lsu_ref(req);
    e.due     = cycle + 2;
    exp_q.push_back(e);
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(negedge clk);
      pre_valid = 1'b0;
      req.op    = LSU_NONE;
    end
  endtask

  // compare on the falling edge while outputs are stable
  always @(negedge clk) begin
    exp_t e;
    if (post_valid === 1'b1) begin
      if (exp_q.size() == 0) begin
        report_failure($sformatf("completion pulse at %0t with no request outstanding",
                                 $time));
      end else begin
        e = exp_q.pop_front();
        if (cycle != e.due) begin
          report_failure($sformatf("mismatch at %0t: pulse in cycle %0d, expected %0d",
                                   $time, cycle, e.due));
        end
        check_word(lsu_res, e.r.res, "o_lsu_res");
        check_flag(misaligned, e.r.mis, "o_misaligned");
      end
    end else if (arst_n === 1'b1 && post_valid !== 1'b0) begin
      report_failure($sformatf("o_post_valid is unknown at %0t", $time));
    end else if (exp_q.size() != 0 && exp_q[0].due <= cycle) begin
      report_failure($sformatf("no completion pulse for the request due in cycle %0d",
                               exp_q[0].due));
    end
  end

  // two cycles per request plus slack for reset and drain
  initial begin
    #((N_REQ * 2 + 100) * PERIOD_NS);
    report_failure("timeout, the run did not finish in time");
  end

  initial begin
    addr_t       word_addrs [32];
    lsu_op_e     op;
    addr_t       addr;
    word_t       d;
    int unsigned k;
    int unsigned w;
    void'($urandom(32'h4095da66));
    pre_valid = 1'b0;
    req       = '0;
    wait (arst_n === 1'b1);
    // quiet outputs after reset
    idle(3);

    // whole memory written once so every later read is defined
    for (int i = 0; i < N_FILL; i++) begin
      issue(LSU_SW, 4 * i, fill_word(i));
    end

    // store words and read them back
    for (int i = 0; i < 32; i++) begin
      word_addrs[i] = 4 * $urandom_range(MEM_WORDS - 1);
      issue(LSU_SW, word_addrs[i], $urandom());
    end
    for (int i = 0; i < 32; i++) begin
      issue(LSU_LW, word_addrs[i], $urandom());
    end

    // byte lanes with the sign bit toggling per offset
    // whole word read shows the other lanes untouched
    for (int off = 0; off < 4; off++) begin
      d    = $urandom();
      d[7] = off[0];
      issue(LSU_SB, 32'h40 + off, d);
      issue(LSU_LB, 32'h40 + off, $urandom());
      issue(LSU_LBU, 32'h40 + off, $urandom());
      issue(LSU_LW, 32'h40, $urandom());
    end
    // half lanes with a negative low half and a positive high half
    for (int off = 0; off < 4; off += 2) begin
      d     = $urandom();
      d[15] = (off == 0);
      issue(LSU_SH, 32'h80 + off, d);
      issue(LSU_LH, 32'h80 + off, $urandom());
      issue(LSU_LHU, 32'h80 + off, $urandom());
      issue(LSU_LW, 32'h80, $urandom());
    end

    // refused requests then a read of the untouched word
    for (int off = 1; off < 4; off++) begin
      issue(LSU_SW, 32'hc0 + off, $urandom());
      issue(LSU_LW, 32'hc0 + off, $urandom());
      issue(LSU_LW, 32'hc0, $urandom());
    end
    for (int off = 1; off < 4; off += 2) begin
      issue(LSU_SH, 32'hc4 + off, $urandom());
      issue(LSU_LH, 32'hc4 + off, $urandom());
      issue(LSU_LW, 32'hc4, $urandom());
    end

    // random mix with every store read back on the next cycle
    for (int i = 0; i < N_MIX / 2; i++) begin
      op   = random_op();
      addr = random_addr(op);
      issue(op, addr, $urandom());
      if (is_store(op)) begin
        issue(random_load_op(), addr, $urandom());
      end else begin
        op = random_op();
        issue(op, random_addr(op), $urandom());
      end
    end

    // high aliases land on the low words
    for (int i = 0; i < N_WRAP / 2; i++) begin
      w = $urandom_range(MEM_WORDS - 1);
      k = $urandom_range(255, 1);
      issue(LSU_SW, w * 4 + k * MEM_BYTES, $urandom());
      issue(LSU_LW, w * 4, $urandom());
    end

    // last pulse lands two cycles after the last request
    idle(4);
    if (exp_q.size() != 0) begin
      report_failure($sformatf("%0d requests never completed", exp_q.size()));
    end else begin
      $display("TEST OK");
      $finish;
    end
  end

endmodule

// File: dv/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
  parameter int PERIOD_NS    = 100,
  parameter int RESET_CYCLES = 4
) (
  output logic o_clk,
  output logic o_arst_n
);

  // free-running clock, starts low
  initial begin
    o_clk = 1'b0;
    forever #(PERIOD_NS / 2) o_clk = ~o_clk;
  end

  // held over a few rising edges
  // released on a falling edge, away from the sampling edge
  initial begin
    o_arst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge o_clk);
    @(negedge o_clk);
    o_arst_n = 1'b1;
  end

endmodule

// File: hw/lsu_data_sram.sv
`timescale 1ns/1ps

module lsu_data_sram #(
  // depth in words, power of two
  parameter int MEM_WORDS
) (
  input  logic             i_clk,
  input  logic             i_arst_n,
  input  lsu_pkg::mem_wr_t i_wr,
  input  lsu_pkg::ld_tag_t i_tag,
  output lsu_pkg::word_t   o_rd_data,
  output lsu_pkg::ld_tag_t o_tag
);

  import lsu_pkg::*;

  localparam int IDX_W = $clog2(MEM_WORDS);

  // word array, written per byte lane
  word_t mem [MEM_WORDS];

  // word index, upper address bits dropped so it wraps
  logic [IDX_W-1:0] idx;

  // stage-one registers
  word_t   rd_q;
  ld_tag_t tag_q;

  assign idx = i_wr.addr[IDX_W+1:2];

  // byte-lane write
  // only enabled lanes change
  always_ff @(posedge i_clk) begin
    if (i_wr.we) begin
      for (int b = 0; b < 4; b++) begin
        if (i_wr.byte_en[b]) begin
          mem[idx][b*8 +: 8] <= i_wr.data[b*8 +: 8];
        end
      end
    end
  end

  // registered read every cycle
  // old word seen when a write hits the same index
  always_ff @(posedge i_clk) begin
    rd_q <= mem[idx];
  end

  // tag moves alongside the read data
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      tag_q <= '0;
    end else begin
      tag_q <= i_tag;
    end
  end

  assign o_rd_data = rd_q;
  assign o_tag     = tag_q;

  // store_align must keep enables quiet for loads and refused stores
  a_be_needs_we : assert property (
    @(posedge i_clk) disable iff (!i_arst_n)
    (|i_wr.byte_en) |-> i_wr.we
  ) else $error("byte enables set without write enable");

endmodule

// File: hw/lsu_load_extend.sv
`timescale 1ns/1ps

module lsu_load_extend (
  input  logic             i_clk,
  input  logic             i_arst_n,
  input  lsu_pkg::word_t   i_rd_data,
  input  lsu_pkg::ld_tag_t i_tag,
  output lsu_pkg::word_t   o_lsu_res,
  output logic             o_misaligned,
  output logic             o_post_valid
);

  import lsu_pkg::*;

  logic [7:0]  sel_byte;
  logic [15:0] sel_half;
  word_t       ext_res;

  // stage-two registers
  word_t res_q;
  logic  mis_q;
  logic  valid_q;

  // pick the addressed byte
  assign sel_byte = i_rd_data[{i_tag.offset, 3'b000} +: 8];

  // half is aligned here, bit 1 picks upper or lower
  assign sel_half = i_tag.offset[1] ? i_rd_data[31:16] : i_rd_data[15:0];

  // extension per load type
  // stores, idle slots and refused requests give zero
  always_comb begin
    ext_res = '0;
    if (i_tag.valid && !i_tag.misaligned) begin
      case (i_tag.op)
        LSU_LB:  ext_res = {{24{sel_byte[7]}}, sel_byte};
        LSU_LH:  ext_res = {{16{sel_half[15]}}, sel_half};
        LSU_LW:  ext_res = i_rd_data;
        LSU_LBU: ext_res = {24'b0, sel_byte};
        LSU_LHU: ext_res = {16'b0, sel_half};
        default: ext_res = '0;
      endcase
    end
  end

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      res_q   <= '0;
      mis_q   <= 1'b0;
      valid_q <= 1'b0;
    end else begin
      res_q   <= ext_res;
      // already qualified by valid upstream
      mis_q   <= i_tag.misaligned;
      // one pulse per accepted request
      valid_q <= i_tag.valid;
    end
  end

  assign o_lsu_res    = res_q;
  assign o_misaligned = mis_q;
  assign o_post_valid = valid_q;

  // relies on the flag qualification two stages back
  a_mis_with_valid : assert property (
    @(posedge i_clk) disable iff (!i_arst_n)
    o_misaligned |-> o_post_valid
  ) else $error("misaligned flag without completion pulse");

endmodule

// File: hw/lsu_pkg.sv
package lsu_pkg;

  // data word as seen by the core
  typedef logic [31:0] word_t;

  // full byte address from the agu
  typedef logic [31:0] addr_t;

  // one enable per byte lane of a word
  typedef logic [3:0] byte_en_t;

  // memory operation
  // loads and stores share one code space
  typedef enum logic [3:0] {
    LSU_NONE = 4'd0,
    LSU_LB   = 4'd1,
    LSU_LH   = 4'd2,
    LSU_LW   = 4'd3,
    LSU_LBU  = 4'd4,
    LSU_LHU  = 4'd5,
    LSU_SB   = 4'd6,
    LSU_SH   = 4'd7,
    LSU_SW   = 4'd8
  } lsu_op_e;

  // request from the execute stage
  typedef struct packed {
    // what to do
    lsu_op_e op;
    // byte address, low bits pick the lane
    addr_t   addr;
    // store data, right-aligned
    word_t   wdata;
  } lsu_req_t;

  // write command into the data memory
  // addr also drives the read index
  typedef struct packed {
    logic     we;
    addr_t    addr;
    byte_en_t byte_en;
    // data already placed in its lanes
    word_t    data;
  } mem_wr_t;

  // side info that rides next to the read data
  typedef struct packed {
    // a request was accepted
    logic       valid;
    // decides the extension in stage two
    lsu_op_e    op;
    // byte offset inside the word
    logic [1:0] offset;
    // refused request, only set with valid
    logic       misaligned;
  } ld_tag_t;

endpackage

// File: hw/lsu_store_align.sv
`timescale 1ns/1ps

module lsu_store_align (
  input  logic              i_pre_valid,
  input  lsu_pkg::lsu_req_t i_req,
  output lsu_pkg::mem_wr_t  o_wr,
  output lsu_pkg::ld_tag_t  o_tag
);

  import lsu_pkg::*;

  logic       size_half;
  logic       size_word;
  logic       is_store;
  logic       misaligned;
  logic       do_write;
  logic [1:0] offset;
  byte_en_t   lane_en;
  word_t      lane_data;

  assign offset = i_req.addr[1:0];

  // access size and direction from the opcode
  // byte size when neither flag is set
  always_comb begin
    size_half = 1'b0;
    size_word = 1'b0;
    is_store  = 1'b0;
    case (i_req.op)
      LSU_LH, LSU_LHU: size_half = 1'b1;
      LSU_LW:          size_word = 1'b1;
      LSU_SB:          is_store  = 1'b1;
      LSU_SH: begin
        size_half = 1'b1;
        is_store  = 1'b1;
      end
      LSU_SW: begin
        size_word = 1'b1;
        is_store  = 1'b1;
      end
      default: ;
    endcase
  end

  // half needs bit 0 clear, word needs both clear
  assign misaligned = (size_half & offset[0]) | (size_word & (|offset));

  // the only place that decides a real write
  assign do_write = i_pre_valid & is_store & ~misaligned;

  // place store data into its lanes
  // replicated so the enables alone pick the byte
  always_comb begin
    if (size_word) begin
      lane_en   = 4'b1111;
      lane_data = i_req.wdata;
    end else if (size_half) begin
      lane_en   = offset[1] ? 4'b1100 : 4'b0011;
      lane_data = {2{i_req.wdata[15:0]}};
    end else begin
      lane_en   = 4'b0001 << offset;
      lane_data = {4{i_req.wdata[7:0]}};
    end
  end

  always_comb begin
    o_wr.we      = do_write;
    // read index comes from here too
    o_wr.addr    = i_req.addr;
    // no enables unless writing
    o_wr.byte_en = do_write ? lane_en : '0;
    o_wr.data    = lane_data;

    o_tag.valid      = i_pre_valid;
    o_tag.op         = i_req.op;
    o_tag.offset     = offset;
    // flag only for accepted requests
    o_tag.misaligned = i_pre_valid & misaligned;
  end

endmodule

// File: hw/lsu_top.sv
`timescale 1ns/1ps

module lsu_top #(
  // data memory depth in words
  parameter int MEM_WORDS = 256
) (
  input  logic              i_clk,
  input  logic              i_arst_n,
  input  logic              i_pre_valid,
  input  lsu_pkg::lsu_req_t i_req,
  output lsu_pkg::word_t    o_lsu_res,
  output logic              o_misaligned,
  output logic              o_post_valid
);

  import lsu_pkg::*;

  // stage zero, straight out of the aligner
  mem_wr_t wr_cmd;
  ld_tag_t tag_s0;

  // stage one, registered in the memory
  word_t   rd_data;
  ld_tag_t tag_s1;

  // decode, alignment check, lane placement
  lsu_store_align u_store_align (
    .i_pre_valid (i_pre_valid),
    .i_req       (i_req),
    .o_wr        (wr_cmd),
    .o_tag       (tag_s0)
  );

  // write at the first edge, read data one cycle later
  lsu_data_sram #(
    .MEM_WORDS (MEM_WORDS)
  ) u_data_sram (
    .i_clk     (i_clk),
    .i_arst_n  (i_arst_n),
    .i_wr      (wr_cmd),
    .i_tag     (tag_s0),
    .o_rd_data (rd_data),
    .o_tag     (tag_s1)
  );

  // byte or half select and extension
  // result out after the second edge
  lsu_load_extend u_load_extend (
    .i_clk        (i_clk),
    .i_arst_n     (i_arst_n),
    .i_rd_data    (rd_data),
    .i_tag        (tag_s1),
    .o_lsu_res    (o_lsu_res),
    .o_misaligned (o_misaligned),
    .o_post_valid (o_post_valid)
  );

endmodule

// File: sim.f
hw/lsu_pkg.sv
hw/lsu_store_align.sv
hw/lsu_data_sram.sv
hw/lsu_load_extend.sv
hw/lsu_top.sv
dv/tb_clock.sv
dv/lsu_tb.sv
